/* source/osc_pkg.sv */
// shared types, widths and register offsets
// for one oscilloscope channel

`default_nettype none

package osc_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // number of external event sources
  localparam int unsigned EVN_W = 6;
  // accumulator width, sample plus decimation range
  localparam int unsigned SUM_W = 16 + 17;

  typedef logic signed [15:0]      smp_dat_t;
  typedef logic        [31:0]      cnt_t;
  typedef logic        [16:0]      dec_t;
  typedef logic        [3:0]       shr_t;
  typedef logic        [EVN_W-1:0] evn_vec_t;
  typedef logic        [7:0]       bus_addr_t;
  typedef logic        [31:0]      bus_dat_t;
  typedef logic signed [SUM_W-1:0] sum_t;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // sample stream beat
  typedef struct packed {
    logic     vld;
    smp_dat_t dat;
  } smp_t;

  // bus request, held for one cycle
  typedef struct packed {
    logic      wen;
    logic      ren;
    bus_addr_t addr;
    bus_dat_t  wdata;
  } bus_req_t;

  // channel events
  typedef struct packed {
    // acquisition done
    logic lst;
    // edge trigger fired
    logic lvl;
    // software pulses from REG_CTL
    logic trg;
    logic stp;
    logic str;
    logic rst;
  } evn_t;

  // configuration seen by the stream blocks
  typedef struct packed {
    cnt_t     pre;
    cnt_t     pst;
    smp_dat_t neg;
    smp_dat_t pos;
    logic     edg;
    cnt_t     hld;
    dec_t     dec;
    shr_t     shr;
    logic     avg;
  } cfg_t;

  // acquisition FSM
  typedef enum logic [1:0] {
    ACQ_IDLE,
    ACQ_PRE,
    ACQ_POST
  } acq_state_t;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  localparam bus_addr_t REG_CTL     = 8'h00;
  localparam bus_addr_t REG_IRQ_ENA = 8'h08;
  localparam bus_addr_t REG_IRQ_STS = 8'h0C;
  localparam bus_addr_t REG_MSK_RST = 8'h10;
  localparam bus_addr_t REG_MSK_STR = 8'h14;
  localparam bus_addr_t REG_MSK_STP = 8'h18;
  localparam bus_addr_t REG_MSK_TRG = 8'h1C;
  localparam bus_addr_t REG_PRE     = 8'h20;
  localparam bus_addr_t REG_PST     = 8'h24;
  localparam bus_addr_t REG_STS_PRE = 8'h28;
  localparam bus_addr_t REG_STS_PST = 8'h2C;
  localparam bus_addr_t REG_NEG     = 8'h30;
  localparam bus_addr_t REG_POS     = 8'h34;
  localparam bus_addr_t REG_EDG     = 8'h38;
  localparam bus_addr_t REG_HLD     = 8'h3C;
  localparam bus_addr_t REG_DEC     = 8'h40;
  localparam bus_addr_t REG_SHR     = 8'h44;
  localparam bus_addr_t REG_AVG     = 8'h48;

endpackage

`default_nettype wire

/* source/osc_regset.sv */
// bus-mapped register set of the channel
// event masks, software event pulses, sticky interrupts

`default_nettype none

module osc_regset import osc_pkg::*; (
  input  logic     bus,
  input  logic     ctl_rst,
  // system bus
  input  bus_req_t bus_req_i,
  output bus_dat_t bus_rdata_o,
  output logic     bus_ack_o,
  // events
  input  evn_vec_t evn_ext_i,
  input  logic     evn_lvl_i,
  input  logic     evn_lst_i,
  output evn_t     evn_o,
  // acquisition status
  input  cnt_t     sts_pre_i,
  input  cnt_t     sts_pst_i,
  input  logic     sts_run_i,
  input  logic     sts_trg_i,
  // configuration and controls
  output cfg_t     cfg_o,
  output logic     ctl_srst_o,
  output logic     ctl_str_o,
  output logic     ctl_stp_o,
  output logic     ctl_trg_o,
  output logic     irq_o
);

  cfg_t       cfg_q;
  evn_vec_t   msk_rst_q;
  evn_vec_t   msk_str_q;
  evn_vec_t   msk_stp_q;
  evn_vec_t   msk_trg_q;
  logic [3:0] irq_ena_q;
  logic [3:0] irq_sts_q;
  logic [3:0] irq_set;
  logic [3:0] irq_clr;
  // software pulses, rst str stp trg from bit 0 up
  logic [3:0] sw_evn_q;

  ////////////////////////////////////////
  // bus write side
  ////////////////////////////////////////

  // every request answered next cycle
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      bus_ack_o <= 1'b0;
    end else begin
      bus_ack_o <= bus_req_i.wen | bus_req_i.ren;
    end
  end

  // configuration and masks
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg_q     <= '0;
      msk_rst_q <= '0;
      msk_str_q <= '0;
      msk_stp_q <= '0;
      msk_trg_q <= '0;
      irq_ena_q <= '0;
    end else if (bus_req_i.wen) begin
      case (bus_req_i.addr)
        REG_IRQ_ENA: irq_ena_q <= bus_req_i.wdata[3:0];
        REG_MSK_RST: msk_rst_q <= bus_req_i.wdata[EVN_W-1:0];
        REG_MSK_STR: msk_str_q <= bus_req_i.wdata[EVN_W-1:0];
        REG_MSK_STP: msk_stp_q <= bus_req_i.wdata[EVN_W-1:0];
        REG_MSK_TRG: msk_trg_q <= bus_req_i.wdata[EVN_W-1:0];
        REG_PRE:     cfg_q.pre <= bus_req_i.wdata;
        REG_PST:     cfg_q.pst <= bus_req_i.wdata;
        REG_NEG:     cfg_q.neg <= bus_req_i.wdata[15:0];
        REG_POS:     cfg_q.pos <= bus_req_i.wdata[15:0];
        REG_EDG:     cfg_q.edg <= bus_req_i.wdata[0];
        REG_HLD:     cfg_q.hld <= bus_req_i.wdata;
        REG_DEC:     cfg_q.dec <= bus_req_i.wdata[16:0];
        REG_SHR:     cfg_q.shr <= bus_req_i.wdata[3:0];
        REG_AVG:     cfg_q.avg <= bus_req_i.wdata[0];
        default:     ;
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // write to REG_CTL gives one-cycle pulses
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sw_evn_q <= '0;
    end else if (bus_req_i.wen && bus_req_i.addr == REG_CTL) begin
      sw_evn_q <= bus_req_i.wdata[3:0];
    end else begin
      sw_evn_q <= '0;
    end
  end

  assign evn_o = '{
    lst: evn_lst_i,
    lvl: evn_lvl_i,
    trg: sw_evn_q[3],
    stp: sw_evn_q[2],
    str: sw_evn_q[1],
    rst: sw_evn_q[0]
  };

  ////////////////////////////////////////
  // event selection
  ////////////////////////////////////////

  // any masked external source fires the control
  assign ctl_srst_o = |(evn_ext_i & msk_rst_q);
  assign ctl_str_o  = |(evn_ext_i & msk_str_q);
  assign ctl_stp_o  = |(evn_ext_i & msk_stp_q);
  assign ctl_trg_o  = |(evn_ext_i & msk_trg_q);

  ////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////

  assign irq_set = {ctl_trg_o, ctl_stp_o, ctl_str_o, ctl_srst_o};
  // write one to clear
  assign irq_clr = (bus_req_i.wen && bus_req_i.addr == REG_IRQ_STS) ?
                   bus_req_i.wdata[3:0] : 4'b0000;

  // new events win over clear and software reset
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts_q <= '0;
      irq_o     <= 1'b0;
    end else begin
      irq_sts_q <= (irq_sts_q & ~irq_clr & ~{4{ctl_srst_o}}) | irq_set;
      irq_o     <= |(irq_sts_q & irq_ena_q);
    end
  end

  ////////////////////////////////////////
  // bus read side
  ////////////////////////////////////////

  // unmapped offsets read zero
  always_ff @(posedge bus) begin
    case (bus_req_i.addr)
      REG_CTL:     bus_rdata_o <= {28'b0, sts_trg_i, 1'b0, sts_run_i, 1'b0};
      REG_IRQ_ENA: bus_rdata_o <= {28'b0, irq_ena_q};
      REG_IRQ_STS: bus_rdata_o <= {28'b0, irq_sts_q};
      REG_MSK_RST: bus_rdata_o <= bus_dat_t'(msk_rst_q);
      REG_MSK_STR: bus_rdata_o <= bus_dat_t'(msk_str_q);
      REG_MSK_STP: bus_rdata_o <= bus_dat_t'(msk_stp_q);
      REG_MSK_TRG: bus_rdata_o <= bus_dat_t'(msk_trg_q);
      REG_PRE:     bus_rdata_o <= cfg_q.pre;
      REG_PST:     bus_rdata_o <= cfg_q.pst;
      REG_STS_PRE: bus_rdata_o <= sts_pre_i;
      REG_STS_PST: bus_rdata_o <= sts_pst_i;
      // thresholds read back zero extended
      REG_NEG:     bus_rdata_o <= {16'b0, cfg_q.neg};
      REG_POS:     bus_rdata_o <= {16'b0, cfg_q.pos};
      REG_EDG:     bus_rdata_o <= {31'b0, cfg_q.edg};
      REG_HLD:     bus_rdata_o <= cfg_q.hld;
      REG_DEC:     bus_rdata_o <= {15'b0, cfg_q.dec};
      REG_SHR:     bus_rdata_o <= {28'b0, cfg_q.shr};
      REG_AVG:     bus_rdata_o <= {31'b0, cfg_q.avg};
      default:     bus_rdata_o <= '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/osc_dec_avg.sv */
// decimator with optional summing and arithmetic right shift

`default_nettype none

module osc_dec_avg import osc_pkg::*; (
  input  logic bus,
  input  logic ctl_rst,
  input  logic ctl_srst_i,
  input  cfg_t cfg_i,
  input  smp_t sti_i,
  output smp_t sto_o
);

  dec_t     dec_lim;
  dec_t     cnt_q;
  logic     grp_end;
  sum_t     sum_q;
  sum_t     sum_base;
  sum_t     sum_nxt;
  logic     vld_q;
  smp_dat_t dat_q;

  // factor of zero behaves as one
  assign dec_lim = (cfg_i.dec == '0) ? dec_t'(1) : cfg_i.dec;
  // last sample of a group, also catches a factor lowered mid group
  assign grp_end = (cnt_q >= dec_t'(dec_lim - dec_t'(1)));

  // first sample of a group starts a fresh sum
  assign sum_base = (cnt_q == '0) ? sum_t'(0) : sum_q;
  assign sum_nxt  = sum_base + sum_t'(sti_i.dat);

  // group counter and output strobe
  always_ff @(posedge bus) begin
    if (ctl_rst || ctl_srst_i) begin
      cnt_q <= '0;
      vld_q <= 1'b0;
    end else begin
      vld_q <= sti_i.vld & grp_end;
      if (sti_i.vld) begin
        cnt_q <= grp_end ? '0 : dec_t'(cnt_q + dec_t'(1));
      end
    end
  end

  // running sum
  always_ff @(posedge bus) begin
    if (sti_i.vld) begin
      sum_q <= sum_nxt;
    end
  end

  // averaged or plain decimated sample
  always_ff @(posedge bus) begin
    if (sti_i.vld && grp_end) begin
      if (cfg_i.avg) begin
        dat_q <= smp_dat_t'(sum_nxt >>> cfg_i.shr);
      end else begin
        dat_q <= sti_i.dat;
      end
    end
  end

  assign sto_o = '{vld: vld_q, dat: dat_q};

endmodule

`default_nettype wire

/* source/osc_edge.sv */
// edge trigger with hysteresis and hold-off
// stream registered through unchanged

`default_nettype none

module osc_edge import osc_pkg::*; (
  input  logic bus,
  input  logic ctl_rst,
  input  logic ctl_srst_i,
  input  cfg_t cfg_i,
  input  smp_t sti_i,
  output smp_t sto_o,
  output logic lvl_o
);

  logic     arm_q;
  cnt_t     hld_q;
  logic     hld_act;
  logic     arm_cnd;
  logic     fire_cnd;
  logic     fire;
  logic     vld_q;
  smp_dat_t dat_q;

  // edg 0 rising, edg 1 falling
  assign arm_cnd  = cfg_i.edg ? (sti_i.dat > cfg_i.pos) : (sti_i.dat < cfg_i.neg);
  assign fire_cnd = cfg_i.edg ? (sti_i.dat <= cfg_i.neg) : (sti_i.dat >= cfg_i.pos);

  assign hld_act = (hld_q != '0);
  assign fire    = sti_i.vld & arm_q & fire_cnd & ~hld_act;

  always_ff @(posedge bus) begin
    if (ctl_rst || ctl_srst_i) begin
      arm_q <= 1'b0;
      hld_q <= '0;
      lvl_o <= 1'b0;
      vld_q <= 1'b0;
    end else begin
      lvl_o <= fire;
      vld_q <= sti_i.vld;
      if (sti_i.vld) begin
        // crossing consumes the arm, even when held off
        if (arm_q && fire_cnd) begin
          arm_q <= 1'b0;
        end else if (arm_cnd) begin
          arm_q <= 1'b1;
        end
        // hold-off counts valid samples only
        if (fire) begin
          hld_q <= cfg_i.hld;
        end else if (hld_act) begin
          hld_q <= hld_q - cnt_t'(1);
        end
      end
    end
  end

  always_ff @(posedge bus) begin
    dat_q <= sti_i.dat;
  end

  assign sto_o = '{vld: vld_q, dat: dat_q};

endmodule

`default_nettype wire

/* source/osc_acq.sv */
// acquisition sequencer
// pre-trigger count, trigger accept, post-trigger count

`default_nettype none

module osc_acq import osc_pkg::*; (
  input  logic bus,
  input  logic ctl_rst,
  input  logic ctl_srst_i,
  input  logic ctl_str_i,
  input  logic ctl_stp_i,
  input  logic ctl_trg_i,
  input  logic lvl_i,
  input  cfg_t cfg_i,
  input  smp_t sti_i,
  output smp_t sto_o,
  output logic sto_lst_o,
  output cnt_t sts_pre_o,
  output cnt_t sts_pst_o,
  output logic sts_run_o,
  output logic sts_trg_o,
  output logic evn_lst_o
);

  acq_state_t st_q;
  cnt_t       pre_q;
  cnt_t       pst_q;
  cnt_t       pst_nxt;
  logic       trg_q;
  logic       halt;
  logic       trg_acc;
  logic       pst_end;
  logic       fwd;
  logic       vld_q;
  logic       lst_q;
  smp_dat_t   dat_q;

  // stop or software reset ends everything at once
  assign halt    = ctl_srst_i | ctl_stp_i;
  // trigger only after enough pre samples
  assign trg_acc = (ctl_trg_i | lvl_i) & (pre_q >= cfg_i.pre);
  assign pst_nxt = pst_q + cnt_t'(1);
  assign pst_end = (st_q == ACQ_POST) & sti_i.vld & (pst_nxt >= cfg_i.pst);
  assign fwd     = sti_i.vld & (st_q != ACQ_IDLE) & ~halt;

  ////////////////////////////////////////
  // state and counters
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      st_q  <= ACQ_IDLE;
      pre_q <= '0;
      pst_q <= '0;
      trg_q <= 1'b0;
    end else if (halt) begin
      st_q <= ACQ_IDLE;
      if (ctl_srst_i) begin
        trg_q <= 1'b0;
      end
    end else begin
      case (st_q)
        ACQ_IDLE: begin
          if (ctl_str_i) begin
            st_q  <= ACQ_PRE;
            pre_q <= '0;
            pst_q <= '0;
            trg_q <= 1'b0;
          end
        end
        ACQ_PRE: begin
          // saturating pre count
          if (sti_i.vld && pre_q != '1) begin
            pre_q <= pre_q + cnt_t'(1);
          end
          if (trg_acc) begin
            st_q  <= ACQ_POST;
            trg_q <= 1'b1;
          end
        end
        ACQ_POST: begin
          if (sti_i.vld) begin
            pst_q <= pst_nxt;
          end
          if (pst_end) begin
            st_q <= ACQ_IDLE;
          end
        end
        default: st_q <= ACQ_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // output stream
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      vld_q <= 1'b0;
      lst_q <= 1'b0;
    end else begin
      vld_q <= fwd;
      lst_q <= fwd & pst_end;
    end
  end

  always_ff @(posedge bus) begin
    dat_q <= sti_i.dat;
  end

  assign sto_o     = '{vld: vld_q, dat: dat_q};
  assign sto_lst_o = lst_q;
  assign evn_lst_o = lst_q;

  assign sts_pre_o = pre_q;
  assign sts_pst_o = pst_q;
  assign sts_run_o = (st_q != ACQ_IDLE);
  assign sts_trg_o = trg_q;

endmodule

`default_nettype wire

/* source/osc_top.sv */
// oscilloscope channel top level
// register set plus decimator, edge trigger and sequencer

`default_nettype none

module osc_top import osc_pkg::*; (
  input  logic     bus,
  input  logic     ctl_rst,
  input  bus_req_t bus_req_i,
  input  smp_t     adc_i,
  input  evn_vec_t evn_ext_i,
  output bus_dat_t bus_rdata_o,
  output logic     bus_ack_o,
  output smp_t     sto_o,
  output logic     sto_lst_o,
  output evn_t     evn_o,
  output logic     irq_o
);

  cfg_t cfg;
  // acquisition controls
  logic ctl_srst;
  logic ctl_str;
  logic ctl_stp;
  logic ctl_trg;
  // acquisition status
  cnt_t sts_pre;
  cnt_t sts_pst;
  logic sts_run;
  logic sts_trg;
  // stream stages and events
  smp_t dec_sto;
  smp_t edg_sto;
  logic lvl;
  logic lst;

  osc_regset regset_inst (
    .bus         (bus),
    .ctl_rst     (ctl_rst),
    .bus_req_i   (bus_req_i),
    .evn_ext_i   (evn_ext_i),
    .evn_lvl_i   (lvl),
    .evn_lst_i   (lst),
    .sts_pre_i   (sts_pre),
    .sts_pst_i   (sts_pst),
    .sts_run_i   (sts_run),
    .sts_trg_i   (sts_trg),
    .bus_rdata_o (bus_rdata_o),
    .bus_ack_o   (bus_ack_o),
    .cfg_o       (cfg),
    .evn_o       (evn_o),
    .ctl_srst_o  (ctl_srst),
    .ctl_str_o   (ctl_str),
    .ctl_stp_o   (ctl_stp),
    .ctl_trg_o   (ctl_trg),
    .irq_o       (irq_o)
  );

  osc_dec_avg dec_avg_inst (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .ctl_srst_i (ctl_srst),
    .cfg_i      (cfg),
    .sti_i      (adc_i),
    .sto_o      (dec_sto)
  );

  osc_edge edge_inst (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .ctl_srst_i (ctl_srst),
    .cfg_i      (cfg),
    .sti_i      (dec_sto),
    .sto_o      (edg_sto),
    .lvl_o      (lvl)
  );

  osc_acq acq_inst (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .ctl_srst_i (ctl_srst),
    .ctl_str_i  (ctl_str),
    .ctl_stp_i  (ctl_stp),
    .ctl_trg_i  (ctl_trg),
    .lvl_i      (lvl),
    .cfg_i      (cfg),
    .sti_i      (edg_sto),
    .sto_o      (sto_o),
    .sto_lst_o  (sto_lst_o),
    .sts_pre_o  (sts_pre),
    .sts_pst_o  (sts_pst),
    .sts_run_o  (sts_run),
    .sts_trg_o  (sts_trg),
    .evn_lst_o  (lst)
  );

endmodule

`default_nettype wire

/* tests/tb_osc.sv */
// testbench for the oscilloscope channel
// bus tasks, table-driven register and stream scenarios, checks

`default_nettype none

module tb_osc import osc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TMO = 200;

  // register table entry, write value and expected readback
  typedef struct {
    bus_addr_t addr;
    bus_dat_t  wdata;
    bus_dat_t  exp;
  } reg_ent_t;

  // decimation scenario entry
  typedef struct {
    int dec;
    int avg;
    int shr;
  } dec_ent_t;

  logic     bus;
  logic     ctl_rst;
  bus_req_t bus_req;
  smp_t     adc;
  evn_vec_t evn_ext;
  bus_dat_t bus_rdata;
  logic     bus_ack;
  smp_t     sto;
  logic     sto_lst;
  evn_t     evn;
  logic     irq;

  reg_ent_t reg_tab [0:16];
  dec_ent_t dec_tab [0:1];
  smp_dat_t smp_tab [0:15];

  // monitor results
  smp_dat_t out_dat [$];
  logic     out_lst [$];
  int       lvl_cnt;
  int       lst_cnt;

  osc_top osc_top_inst (
    .bus         (bus),
    .ctl_rst     (ctl_rst),
    .bus_req_i   (bus_req),
    .adc_i       (adc),
    .evn_ext_i   (evn_ext),
    .bus_rdata_o (bus_rdata),
    .bus_ack_o   (bus_ack),
    .sto_o       (sto),
    .sto_lst_o   (sto_lst),
    .evn_o       (evn),
    .irq_o       (irq)
  );

  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;
  end

  // outputs are stable mid cycle
  always begin
    @(posedge bus);
    #5;
    if (sto.vld) begin
      out_dat.push_back(sto.dat);
      out_lst.push_back(sto_lst);
    end
    if (evn.lvl) lvl_cnt++;
    if (evn.lst) lst_cnt++;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_fail("value mismatch");
    end
  endtask

  // next edge plus drive delay
  task automatic step();
    @(posedge bus);
    #10;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    while (!bus_ack) begin
      if (n >= TMO) stop_fail("timeout waiting for bus ack");
      step();
      n++;
    end
    // ack belongs to the cycle right after the request
    check("bus_ack_o delay", 32'(n), 32'd0);
  endtask

  task automatic write_reg(input bus_addr_t addr, input bus_dat_t data);
    bus_req = '{wen: 1'b1, ren: 1'b0, addr: addr, wdata: data};
    step();
    bus_req = '0;
    wait_ack();
  endtask

  task automatic read_reg(input bus_addr_t addr, output bus_dat_t data);
    bus_req = '{wen: 1'b0, ren: 1'b1, addr: addr, wdata: '0};
    step();
    bus_req = '0;
    wait_ack();
    data = bus_rdata;
  endtask

  task automatic read_check(input string name, input bus_addr_t addr, input bus_dat_t exp);
    bus_dat_t rd;
    read_reg(addr, rd);
    check(name, rd, exp);
  endtask

  // one cycle on an external event line
  task automatic pulse_ext(input int b);
    evn_ext[b] = 1'b1;
    step();
    evn_ext = '0;
  endtask

  task automatic feed(input smp_dat_t d);
    adc = '{vld: 1'b1, dat: d};
    step();
    adc.vld = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  function automatic smp_dat_t noise(input int amp);
    int unsigned r;
    r = $urandom % (2 * amp + 1);
    return smp_dat_t'(int'(r) - amp);
  endfunction

  task automatic wait_outputs(input int n);
    int t;
    t = 0;
    while (out_dat.size() < n) begin
      if (t >= TMO) stop_fail("timeout waiting for output samples");
      step();
      t++;
    end
  endtask

  task automatic clear_mon();
    out_dat.delete();
    out_lst.delete();
    lvl_cnt = 0;
    lst_cnt = 0;
  endtask

  initial begin
    #1_000_000;
    stop_fail("simulation watchdog expired");
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int       sum;
    int       pre_n;
    int       n;
    int       t;

    void'($urandom(32'he91d_02ed));
    ctl_rst = 1'b1;
    bus_req = '0;
    adc     = '0;
    evn_ext = '0;
    clear_mon();

    reg_tab = '{
      '{REG_IRQ_ENA, 32'hffff_ffff, 32'h0000_000f},
      '{REG_MSK_RST, 32'hffff_ffff, 32'h0000_003f},
      '{REG_MSK_STR, 32'h0000_002a, 32'h0000_002a},
      '{REG_MSK_STP, 32'h0000_0015, 32'h0000_0015},
      '{REG_MSK_TRG, 32'hffff_ffc1, 32'h0000_0001},
      '{REG_PRE,     32'h1234_5678, 32'h1234_5678},
      '{REG_PST,     32'h9abc_def0, 32'h9abc_def0},
      '{REG_NEG,     32'hffff_8001, 32'h0000_8001},
      '{REG_POS,     32'h0001_7fff, 32'h0000_7fff},
      '{REG_EDG,     32'h0000_0003, 32'h0000_0001},
      '{REG_HLD,     32'ha5a5_a5a5, 32'ha5a5_a5a5},
      '{REG_DEC,     32'hffff_ffff, 32'h0001_ffff},
      '{REG_SHR,     32'h0000_001f, 32'h0000_000f},
      '{REG_AVG,     32'hffff_fffe, 32'h0000_0000},
      // unmapped offsets
      '{8'h04,       32'hdead_beef, 32'h0000_0000},
      '{8'h4c,       32'h1234_5678, 32'h0000_0000},
      '{8'hfc,       32'hffff_ffff, 32'h0000_0000}
    };
    dec_tab = '{'{4, 0, 0}, '{4, 1, 2}};

    repeat (5) @(posedge bus);
    #10;
    ctl_rst = 1'b0;
    step();
    check("bus_ack_o", 32'(bus_ack), 32'd0);
    check("irq_o", 32'(irq), 32'd0);
    check("sto_o.vld", 32'(sto.vld), 32'd0);
    check("sto_lst_o", 32'(sto_lst), 32'd0);
    check("evn_o", 32'(evn), 32'd0);

    // register readback
    foreach (reg_tab[i]) write_reg(reg_tab[i].addr, reg_tab[i].wdata);
    foreach (reg_tab[i]) read_check($sformatf("reg %h", reg_tab[i].addr),
                                    reg_tab[i].addr, reg_tab[i].exp);

    // base setup, start ext 0, stop ext 2, trigger ext 3
    write_reg(REG_IRQ_ENA, 32'h0);
    write_reg(REG_MSK_RST, 32'h0);
    write_reg(REG_MSK_STR, 32'h01);
    write_reg(REG_MSK_STP, 32'h04);
    write_reg(REG_MSK_TRG, 32'h08);
    write_reg(REG_IRQ_STS, 32'hf);

    // software event pulses
    for (int b = 0; b < 4; b++) begin
      write_reg(REG_CTL, 32'(1 << b));
      check("evn_o[3:0]", 32'(evn[3:0]), 32'(1 << b));
      step();
      check("evn_o[3:0]", 32'(evn[3:0]), 32'd0);
    end

    // sticky status from a masked stop event
    pulse_ext(2);
    read_check("irq_sts", REG_IRQ_STS, 32'h4);
    check("irq_o", 32'(irq), 32'd0);
    write_reg(REG_IRQ_ENA, 32'h4);
    step();
    check("irq_o", 32'(irq), 32'd1);
    write_reg(REG_IRQ_STS, 32'h4);
    read_check("irq_sts", REG_IRQ_STS, 32'h0);
    check("irq_o", 32'(irq), 32'd0);
    write_reg(REG_IRQ_ENA, 32'h0);

    ////////////////////////////////////////
    // decimation and averaging
    ////////////////////////////////////////

    write_reg(REG_PRE, 32'hffff_ffff);
    write_reg(REG_NEG, 32'(-16'sd30000));
    write_reg(REG_POS, 32'd30000);
    write_reg(REG_EDG, 32'd0);
    write_reg(REG_HLD, 32'd0);
    foreach (dec_tab[s]) begin
      write_reg(REG_DEC, 32'(dec_tab[s].dec));
      write_reg(REG_AVG, 32'(dec_tab[s].avg));
      write_reg(REG_SHR, 32'(dec_tab[s].shr));
      foreach (smp_tab[i]) smp_tab[i] = noise(1000);
      pulse_ext(0);
      clear_mon();
      foreach (smp_tab[i]) feed(smp_tab[i]);
      wait_outputs(16 / dec_tab[s].dec);
      for (int g = 0; g < 16 / dec_tab[s].dec; g++) begin
        sum = 0;
        for (int k = 0; k < dec_tab[s].dec; k++) begin
          sum += int'(smp_tab[g * dec_tab[s].dec + k]);
        end
        if (dec_tab[s].avg != 0) begin
          check($sformatf("sto_o.dat avg %0d", g), 32'(out_dat[g]),
                32'(smp_dat_t'(sum >>> dec_tab[s].shr)));
        end else begin
          check($sformatf("sto_o.dat dec %0d", g), 32'(out_dat[g]),
                32'(smp_tab[g * dec_tab[s].dec + dec_tab[s].dec - 1]));
        end
      end
      pulse_ext(2);
    end

    ////////////////////////////////////////
    // edge trigger
    ////////////////////////////////////////

    write_reg(REG_DEC, 32'd1);
    write_reg(REG_AVG, 32'd0);
    write_reg(REG_SHR, 32'd0);
    write_reg(REG_NEG, 32'(-16'sd100));
    write_reg(REG_POS, 32'd100);
    write_reg(REG_HLD, 32'd3);
    clear_mon();
    // second crossing falls inside hold-off
    feed(-200);
    feed(200);
    feed(-200);
    feed(200);
    feed(0);
    feed(-200);
    feed(200);
    idle(4);
    check("lvl pulses rising", 32'(lvl_cnt), 32'd2);

    write_reg(REG_HLD, 32'd0);
    write_reg(REG_EDG, 32'd1);
    clear_mon();
    // zeros let the old hold-off run out
    repeat (4) feed(0);
    // high first, so a rising trigger would fire only once
    feed(200);
    feed(-200);
    feed(200);
    feed(-200);
    idle(4);
    check("lvl pulses falling", 32'(lvl_cnt), 32'd2);

    ////////////////////////////////////////
    // acquisition
    ////////////////////////////////////////

    write_reg(REG_EDG, 32'd0);
    write_reg(REG_PRE, 32'd5);
    write_reg(REG_PST, 32'd7);
    pulse_ext(0);
    clear_mon();
    repeat (8) feed(noise(50));
    feed(-200);
    feed(200);
    n = 0;
    t = 0;
    while (lst_cnt == 0) begin
      if (t >= TMO) stop_fail("timeout waiting for acquisition end");
      feed(noise(50));
      t++;
    end
    idle(4);
    check("evn_o.lst pulses", 32'(lst_cnt), 32'd1);
    // index of the trigger sample, count of samples ahead of it
    pre_n = -1;
    foreach (out_dat[i]) begin
      if (out_dat[i] == 16'sd200 && pre_n < 0) pre_n = i;
      if (out_lst[i]) n++;
    end
    if (pre_n < 0) stop_fail("trigger sample never forwarded");
    check("pre samples ok", 32'(pre_n >= 5), 32'd1);
    check("post samples", 32'(out_dat.size() - pre_n - 1), 32'd7);
    check("sto_lst_o count", 32'(n), 32'd1);
    check("sto_lst_o last", 32'(out_lst[out_dat.size() - 1]), 32'd1);
    read_check("sts_pst", REG_STS_PST, 32'd7);
    read_check("ctl status", REG_CTL, 32'h8);

    ////////////////////////////////////////
    // early trigger and stop
    ////////////////////////////////////////

    write_reg(REG_PRE, 32'd20);
    pulse_ext(0);
    clear_mon();
    repeat (3) feed(noise(50));
    pulse_ext(3);
    read_check("ctl status", REG_CTL, 32'h2);
    repeat (3) feed(noise(50));
    pulse_ext(2);
    idle(3);
    n = out_dat.size();
    repeat (5) feed(noise(50));
    idle(4);
    check("samples after stop", 32'(out_dat.size()), 32'(n));
    check("evn_o.lst pulses", 32'(lst_cnt), 32'd0);
    foreach (out_lst[i]) check("sto_lst_o", 32'(out_lst[i]), 32'd0);
    read_check("ctl status", REG_CTL, 32'h0);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/osc_pkg.sv
source/osc_regset.sv
source/osc_dec_avg.sv
source/osc_edge.sv
source/osc_acq.sv
source/osc_top.sv
tests/tb_osc.sv

/* Makefile */
# Verilator build and run for the oscilloscope channel

VERILATOR ?= verilator
TOP       ?= tb_osc
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
